// ==== design/arb_pkg.sv ====
`default_nettype none

`include "flow_arb_params.svh"

// ---------------------------------------------------------------------------
// Arbitration types shared by the arbiter and the top level
// ---------------------------------------------------------------------------
package arb_pkg;

  // Index of one flow
  // Sized to address every flow of the subsystem
  typedef logic [$clog2(`FLOW_ARB_NUM_FLOWS)-1:0] flow_id_t;

  // One bit per flow
  // Used for requests, grants, valids and readys alike
  typedef logic [`FLOW_ARB_NUM_FLOWS-1:0] flow_vec_t;

endpackage : arb_pkg

`default_nettype wire

// ==== design/flow_arb_core.sv ====
`default_nettype none

// Flow-control core of the arbiter
// Couples the per-flow valid/ready handshakes and the downstream ready
// to a base arbiter that always grants
module flow_arb_core (
  // Same clock and reset as the base arbiter it sits beside
  input  logic               clk,
  input  logic               rst,
  // Base arbiter side
  output arb_pkg::flow_vec_t request,
  input  arb_pkg::flow_vec_t can_grant,
  input  arb_pkg::flow_vec_t grant,
  output logic               enable_priority_update,
  // Per-flow push side
  output arb_pkg::flow_vec_t push_ready,
  input  arb_pkg::flow_vec_t push_valid,
  // Merged pop side
  input  logic               pop_ready,
  output logic               pop_valid
);

  // ---------------------------------------------------------------------------
  // Request and ready steering
  // ---------------------------------------------------------------------------

  // Every waiting flow asks for the output
  assign request = push_valid;

  // Pointer advances only when the winner actually leaves
  assign enable_priority_update = pop_ready;

  // Winner is accepted only while the output can take it
  assign push_ready = can_grant & {$bits(can_grant){pop_ready}};

  // Output is valid whenever anyone waits
  assign pop_valid = |push_valid;

endmodule : flow_arb_core

`default_nettype wire

// ==== design/flow_arb_params.svh ====
`ifndef FLOW_ARB_PARAMS_SVH
`define FLOW_ARB_PARAMS_SVH

// ---------------------------------------------------------------------------
// Subsystem sizing
// ---------------------------------------------------------------------------

// Number of ingress flows competing for the output
`define FLOW_ARB_NUM_FLOWS 4

// Storage entries per ingress FIFO, not counting the head slot
`define FLOW_ARB_FIFO_DEPTH 4

// Width of the payload carried by every beat
`define FLOW_ARB_DATA_W 16

`endif

// ==== design/flow_arb_top.sv ====
`default_nettype none

`include "flow_arb_params.svh"

// Multi-flow arbiter subsystem
// Ingress FIFOs, round-robin arbiter and one output register
module flow_arb_top (
  input  logic                 clk,
  input  logic                 rst,
  input  arb_pkg::flow_vec_t   in_valid,
  input  flow_pkg::flow_data_t in_data [`FLOW_ARB_NUM_FLOWS],
  output arb_pkg::flow_vec_t   in_ready,
  output logic                 out_valid,
  output flow_pkg::flow_beat_t out_beat,
  input  logic                 out_ready
);

  import arb_pkg::*;
  import flow_pkg::*;

  // FIFO heads toward the arbiter
  flow_vec_t  head_valid;
  flow_beat_t head_beat [`FLOW_ARB_NUM_FLOWS];
  flow_vec_t  head_pop;

  // Arbiter to output register
  logic       arb_valid;
  flow_beat_t arb_beat;
  logic       arb_ready;

  // ---------------------------------------------------------------------------
  // Ingress FIFOs
  // ---------------------------------------------------------------------------
  for (genvar i = 0; i < `FLOW_ARB_NUM_FLOWS; i++) begin : g_flow
    flow_beat_t push_beat;

    // Tag each beat with its flow on the way in
    assign push_beat.data = in_data[i];
    assign push_beat.src  = flow_id_t'(i);

    flow_fifo #(
      .DEPTH     (`FLOW_ARB_FIFO_DEPTH),
      .payload_t (flow_beat_t)
    ) i_fifo (
      .clk        (clk),
      .rst        (rst),
      .push_valid (in_valid[i]),
      .push_data  (push_beat),
      .push_ready (in_ready[i]),
      .pop_valid  (head_valid[i]),
      .pop_data   (head_beat[i]),
      .pop_ready  (head_pop[i])
    );
  end

  // ---------------------------------------------------------------------------
  // Arbitration and output stage
  // ---------------------------------------------------------------------------
  flow_rr_arbiter i_arbiter (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .head_beat  (head_beat),
    .head_pop   (head_pop),
    .arb_valid  (arb_valid),
    .arb_beat   (arb_beat),
    .arb_ready  (arb_ready)
  );

  flow_out_reg #(
    .payload_t (flow_beat_t)
  ) i_out_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (arb_valid),
    .in_data   (arb_beat),
    .in_ready  (arb_ready),
    .out_valid (out_valid),
    .out_data  (out_beat),
    .out_ready (out_ready)
  );

endmodule : flow_arb_top

`default_nettype wire

// ==== design/flow_fifo.sv ====
`default_nettype none

`include "flow_arb_params.svh"

// Per-flow ingress FIFO
// Circular buffer behind a registered head slot
module flow_fifo #(
  parameter int  DEPTH     = `FLOW_ARB_FIFO_DEPTH,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_valid,
  input  payload_t push_data,
  output logic     push_ready,
  output logic     pop_valid,
  output payload_t pop_data,
  input  logic     pop_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Buffer storage and head slot
  payload_t         mem [DEPTH];
  payload_t         head_data;
  logic             head_valid;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Handshake and move controls
  logic push_fire;
  logic pop_fire;
  logic head_free;
  logic mem_empty;
  logic mem_full;
  logic bypass;
  logic mem_wr;
  logic mem_rd;

  // ---------------------------------------------------------------------------
  // Control
  // ---------------------------------------------------------------------------
  assign mem_empty = (count == '0);
  assign mem_full  = (count == CNT_W'(DEPTH));

  assign pop_valid = head_valid;
  assign pop_data  = head_data;
  assign pop_fire  = head_valid && pop_ready;

  // A pop frees one buffer slot, so a full FIFO still takes a push
  assign push_ready = !mem_full || pop_fire;
  assign push_fire  = push_valid && push_ready;

  // Head slot refills when empty or being drained
  assign head_free = !head_valid || pop_fire;
  // Empty buffer, push goes straight to the head
  assign bypass    = head_free && mem_empty && push_fire;
  assign mem_rd    = head_free && !mem_empty;
  assign mem_wr    = push_fire && !bypass;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(mem_wr) - CNT_W'(mem_rd);
      if (head_free) begin
        head_valid <= mem_rd || bypass;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Payload path
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= push_data;
    end
    // Oldest buffered beat wins over the incoming one
    if (mem_rd) begin
      head_data <= mem[rd_ptr];
    end else if (bypass) begin
      head_data <= push_data;
    end
  end

endmodule : flow_fifo

`default_nettype wire

// ==== design/flow_out_reg.sv ====
`default_nettype none

// Output pipeline register
// Single entry, full throughput, loads whenever empty or draining
module flow_out_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // Input transfer this cycle
  logic load;

  // ---------------------------------------------------------------------------
  // Handshake
  // ---------------------------------------------------------------------------

  // Room now, or room after the current beat leaves
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // Drained with nothing behind it
      out_valid <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------------
  // Payload
  // ---------------------------------------------------------------------------
  // Holds still while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule : flow_out_reg

`default_nettype wire

// ==== design/flow_pkg.sv ====
`default_nettype none

`include "flow_arb_params.svh"

// ---------------------------------------------------------------------------
// Payload types carried through the FIFOs and the output register
// ---------------------------------------------------------------------------
package flow_pkg;

  import arb_pkg::*;

  // Raw data word of one beat
  typedef logic [`FLOW_ARB_DATA_W-1:0] flow_data_t;

  // Beat as seen on the output port
  // Data sits in the upper bits, source flow in the lower bits
  typedef struct packed {
    flow_data_t data;
    flow_id_t   src;
  } flow_beat_t;

endpackage : flow_pkg

`default_nettype wire

// ==== design/flow_rr_arbiter.sv ====
`default_nettype none

`include "flow_arb_params.svh"

// Flow-controlled round-robin arbiter
// Picks one FIFO head per cycle and presents it as a single beat
module flow_rr_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  arb_pkg::flow_vec_t   head_valid,
  input  flow_pkg::flow_beat_t head_beat [`FLOW_ARB_NUM_FLOWS],
  output arb_pkg::flow_vec_t   head_pop,
  output logic                 arb_valid,
  output flow_pkg::flow_beat_t arb_beat,
  input  logic                 arb_ready
);

  import arb_pkg::*;
  import flow_pkg::*;

  flow_vec_t request;
  flow_vec_t can_grant;
  flow_vec_t grant;
  logic      enable_priority_update;

  // OR-reduced beat bits of the granted flow
  logic [$bits(flow_beat_t)-1:0] sel_bits;

  // ---------------------------------------------------------------------------
  // Flow control and arbitration
  // ---------------------------------------------------------------------------
  flow_arb_core i_core (
    .clk                    (clk),
    .rst                    (rst),
    .request                (request),
    .can_grant              (can_grant),
    .grant                  (grant),
    .enable_priority_update (enable_priority_update),
    .push_ready             (head_pop),
    .push_valid             (head_valid),
    .pop_ready              (arb_ready),
    .pop_valid              (arb_valid)
  );

  rr_base_arb #(
    .NUM_FLOWS (`FLOW_ARB_NUM_FLOWS)
  ) i_base_arb (
    .clk                    (clk),
    .rst                    (rst),
    .request                (request),
    .enable_priority_update (enable_priority_update),
    .can_grant              (can_grant),
    .grant                  (grant)
  );

  // ---------------------------------------------------------------------------
  // One-hot data mux
  // ---------------------------------------------------------------------------
  always_comb begin
    sel_bits = '0;
    for (int i = 0; i < `FLOW_ARB_NUM_FLOWS; i++) begin
      sel_bits = sel_bits | (head_beat[i] & {$bits(flow_beat_t){grant[i]}});
    end
  end

  assign arb_beat = flow_beat_t'(sel_bits);

endmodule : flow_rr_arbiter

`default_nettype wire

// ==== design/rr_base_arb.sv ====
`default_nettype none

`include "flow_arb_params.svh"

// Round-robin base arbiter
// Grants the first requester at or after the priority pointer
module rr_base_arb #(
  parameter int NUM_FLOWS = `FLOW_ARB_NUM_FLOWS
) (
  input  logic               clk,
  input  logic               rst,
  input  arb_pkg::flow_vec_t request,
  input  logic               enable_priority_update,
  output arb_pkg::flow_vec_t can_grant,
  output arb_pkg::flow_vec_t grant
);

  import arb_pkg::*;

  // Highest priority flow this cycle
  flow_id_t ptr;
  // Winner index and request presence
  flow_id_t gnt_idx;
  logic     any_req;

  // ---------------------------------------------------------------------------
  // Winner search
  // ---------------------------------------------------------------------------
  always_comb begin
    int idx;
    can_grant = '0;
    gnt_idx   = '0;
    any_req   = 1'b0;
    // Walk the flows starting at the pointer, wrapping past the last one
    for (int off = 0; off < NUM_FLOWS; off++) begin
      idx = int'(ptr) + off;
      if (idx >= NUM_FLOWS) begin
        idx = idx - NUM_FLOWS;
      end
      if (!any_req && request[idx]) begin
        any_req        = 1'b1;
        gnt_idx        = flow_id_t'(idx);
        can_grant[idx] = 1'b1;
      end
    end
  end

  // Any request is always served
  assign grant = can_grant;

  // ---------------------------------------------------------------------------
  // Priority pointer
  // ---------------------------------------------------------------------------
  // Moves past the winner only on a cycle the grant is taken
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (enable_priority_update && any_req) begin
      if (gnt_idx == flow_id_t'(NUM_FLOWS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= gnt_idx + 1'b1;
      end
    end
  end

endmodule : rr_base_arb

`default_nettype wire

// ==== flow_arb_top.f ====
+incdir+design
design/arb_pkg.sv
design/flow_pkg.sv
design/flow_fifo.sv
design/rr_base_arb.sv
design/flow_arb_core.sv
design/flow_rr_arbiter.sv
design/flow_out_reg.sv
design/flow_arb_top.sv
sim/tb_clk_gen.sv
sim/flow_arb_tb.sv

// ==== sim/flow_arb_tb.sv ====
`default_nettype none

`include "flow_arb_params.svh"

// Testbench for the multi-flow arbiter subsystem
module flow_arb_tb;

  import arb_pkg::*;
  import flow_pkg::*;

  localparam int NF          = `FLOW_ARB_NUM_FLOWS;
  localparam int DEPTH       = `FLOW_ARB_FIFO_DEPTH;
  localparam int RAND_CYCLES = 300;
  localparam int MEM_DEPTH   = 1024;
  // Worst case beat count over all tests, 20 cycles per beat plus slack
  localparam int TOTAL_BEATS = 4 + 3 * NF + DEPTH + 3 + RAND_CYCLES * NF;
  localparam int TIMEOUT_CYC = TOTAL_BEATS * 20 + 500;

  logic       clk;
  logic       rst;
  flow_vec_t  in_valid;
  flow_data_t in_data [NF];
  flow_vec_t  in_ready;
  logic       out_valid;
  flow_beat_t out_beat;
  logic       out_ready;

  // Expected beats per flow, filled on input transfers
  flow_data_t exp_mem [NF][MEM_DEPTH];
  int         wr_cnt [NF];
  int         rd_cnt [NF];
  // Model of the round-robin pointer
  int         model_ptr;
  int         out_cnt;
  bit         check_order;

  string test_name;
  int    errors;
  int    checks;
  int    test_err_start;
  int    tests_run;
  int    tests_failed;

  tb_clk_gen #(.PERIOD(10)) i_clk_gen (.clk(clk));

  flow_arb_top i_flow_arb_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

  // --------------------------------------------------------------------------
  // Reference model and checking
  // --------------------------------------------------------------------------

  // Next source under the round-robin rule, -1 when nothing is waiting
  function automatic int predict_src(input flow_vec_t backlog, input int ptr);
    int idx;
    for (int off = 0; off < NF; off++) begin
      idx = (ptr + off) % NF;
      if (backlog[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  function automatic bit drained();
    for (int f = 0; f < NF; f++) begin
      if (wr_cnt[f] != rd_cnt[f]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Output side checked first so a same-edge input never counts as backlog
  always @(posedge clk) begin
    flow_vec_t backlog;
    int        src;
    int        exp_src;
    if (!rst) begin
      if (out_valid && out_ready) begin
        src = int'(out_beat.src);
        for (int f = 0; f < NF; f++) begin
          backlog[f] = (wr_cnt[f] != rd_cnt[f]);
        end
        exp_src = predict_src(backlog, model_ptr);
        if (check_order) begin
          check_value("output src", exp_src, src);
        end
        // Model pointer moves past the predicted winner
        if (exp_src >= 0) begin
          model_ptr = (exp_src + 1) % NF;
        end
        if (rd_cnt[src] == wr_cnt[src]) begin
          errors++;
          $display("ERROR: %s got a beat from flow %0d with nothing outstanding",
                   test_name, src);
        end else begin
          check_value("flow data", exp_mem[src][rd_cnt[src]], out_beat.data);
          rd_cnt[src]++;
        end
        out_cnt++;
      end
      for (int f = 0; f < NF; f++) begin
        if (in_valid[f] && in_ready[f]) begin
          exp_mem[f][wr_cnt[f]] = in_data[f];
          wr_cnt[f]++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("ERROR: simulation did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Test FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
    end
  endtask

  // Holds valid until the beat is taken, returns on the transfer edge
  task automatic send_beat(input int f, input flow_data_t d);
    in_valid[f] <= 1'b1;
    in_data[f]  <= d;
    do @(posedge clk); while (!in_ready[f]);
    in_valid[f] <= 1'b0;
  endtask

  // Outstanding counts settle by the falling edge
  task automatic wait_drain();
    @(negedge clk);
    while (!drained()) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int         lat;
    int         accepted;
    int         stalls;
    int         sent;
    int         out_start;
    bit         held_valid;
    flow_beat_t held;
    flow_vec_t  vld;
    void'($urandom(32'hc12ab241));
    rst       = 1'b1;
    in_valid  = '0;
    out_ready = 1'b0;
    for (int f = 0; f < NF; f++) begin
      in_data[f] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    start_test("reset");
    check_value("out_valid", 0, out_valid);
    check_value("in_ready", {NF{1'b1}}, in_ready);
    finish_test();

    // Lone flow, first beat needs FIFO head and output register
    start_test("single_flow");
    check_order = 1'b1;
    out_ready <= 1'b1;
    send_beat(0, flow_data_t'($urandom));
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!out_valid && lat < 10);
    check_value("first beat latency", 2, lat);
    for (int k = 0; k < 3; k++) begin
      send_beat(0, flow_data_t'($urandom));
    end
    wait_drain();
    finish_test();

    // Every flow loaded while stalled, then drained in rotation
    start_test("round_robin");
    out_ready <= 1'b0;
    for (int k = 0; k < 3; k++) begin
      for (int f = 0; f < NF; f++) begin
        in_data[f] <= flow_data_t'($urandom);
      end
      in_valid <= '1;
      @(posedge clk);
      // Three beats fit in every FIFO, so nothing is refused
      check_value("in_ready while loading", {NF{1'b1}}, in_ready);
    end
    in_valid <= '0;
    repeat (2) @(posedge clk);
    out_ready <= 1'b1;
    wait_drain();
    finish_test();

    start_test("back_pressure");
    out_ready   <= 1'b0;
    in_valid[2] <= 1'b1;
    in_data[2]  <= flow_data_t'($urandom);
    accepted   = 0;
    stalls     = 0;
    held_valid = 1'b0;
    while (stalls < 4) begin
      @(posedge clk);
      if (in_ready[2]) begin
        accepted++;
        in_data[2] <= flow_data_t'($urandom);
      end else begin
        stalls++;
      end
      // Stalled output beat must not move
      if (out_valid && held_valid) begin
        check_value("stalled out_beat", held, out_beat);
      end else if (out_valid) begin
        held       = out_beat;
        held_valid = 1'b1;
      end
    end
    check_value("beats taken before full", DEPTH + 2, accepted);
    out_ready <= 1'b1;
    do @(posedge clk); while (!in_ready[2]);
    in_valid[2] <= 1'b0;
    wait_drain();
    finish_test();

    // Random traffic on all flows, order per flow only
    start_test("random");
    check_order = 1'b0;
    out_start   = out_cnt;
    sent        = 0;
    vld         = '0;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(posedge clk);
      out_ready <= ($urandom % 4) != 0;
      for (int f = 0; f < NF; f++) begin
        if (!vld[f] || in_ready[f]) begin
          if (vld[f]) begin
            sent++;
          end
          vld[f] = $urandom % 2;
          in_data[f] <= flow_data_t'($urandom);
        end
      end
      in_valid <= vld;
    end
    out_ready <= 1'b1;
    while (vld != '0) begin
      @(posedge clk);
      for (int f = 0; f < NF; f++) begin
        if (vld[f] && in_ready[f]) begin
          sent++;
          vld[f] = 1'b0;
        end
      end
      in_valid <= vld;
    end
    wait_drain();
    check_value("beats delivered", sent, out_cnt - out_start);
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : flow_arb_tb

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`default_nettype none

// Free-running clock for the testbench
module tb_clk_gen #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule : tb_clk_gen

`default_nettype wire
